// File: rtl/strobe_rx_pkg.sv
// Shared widths and frame encodings for the strobe receive link
// A frame word is two link bytes, high byte first
package strobe_rx_pkg;

	////////////////////////////////////////
	// Link and word widths
	////////////////////////////////////////

	// One byte on the strobe link
	localparam int LINK_BYTE_W = 8;

	// FIFO entry carries the start-of-frame flag above the byte
	localparam int FIFO_W = LINK_BYTE_W + 1;

	// Frame word built from two link bytes
	localparam int WORD_W = 2 * LINK_BYTE_W;

	////////////////////////////////////////
	// Frame encodings
	////////////////////////////////////////

	// Kind code of a data frame
	localparam logic [3:0] KIND_DATA = 4'd1;

	// One frame word seen two ways
	// Header words are read through hdr
	// Payload and check words are read through raw
	typedef union packed {
		struct packed {
			// Frame kind, only KIND_DATA carries payload
			logic [3:0] kind;
			// Payload word count, 1 to 15
			logic [3:0] len;
			// Tag copied onto every payload word
			logic [7:0] tag;
		} hdr;
		logic [WORD_W-1:0] raw;
	} rx_word_u;

endpackage

// File: rtl/strobe_afifo.sv
// Gray-pointer async FIFO, writes on i_dstb_clk and reads on gbl_clk
// Reads are always registered and o_rd_valid flags the output word
// LGFIFO and NFF must both be 2 or more
// Each side has its own asynchronous active-low reset
module strobe_afifo #(
	parameter int LGFIFO = 3,
	parameter int NFF = 2
) (
	// Strobe domain write side
	input  logic                             i_dstb_clk,
	input  logic                             i_wr_reset_n,
	input  logic                             i_wr,
	input  logic [strobe_rx_pkg::FIFO_W-1:0] i_wr_data,
	output logic                             o_wr_full,
	// System domain read side
	input  logic                             gbl_clk,
	input  logic                             i_rd_reset_n,
	input  logic                             i_rd_take,
	output logic                             o_rd_valid,
	output logic [strobe_rx_pkg::FIFO_W-1:0] o_rd_data
);
	import strobe_rx_pkg::*;

	localparam int DEPTH = 1 << LGFIFO;

	// Storage, written only from the strobe domain
	logic [FIFO_W-1:0] mem [DEPTH];

	// Write pointers, one extra bit for wrap
	logic [LGFIFO:0] wr_addr;
	logic [LGFIFO:0] wr_addr_nxt;
	logic [LGFIFO:0] wr_gray;
	logic            wr_push;

	// Read pointers
	logic [LGFIFO:0] rd_addr;
	logic [LGFIFO:0] rd_addr_nxt;
	logic [LGFIFO:0] rd_gray;
	logic            rd_empty;
	logic            rd_load;
	logic            rd_pull;

	// Synchronizer chains, oldest stage at the top index
	logic [NFF-1:0][LGFIFO:0] rgray_sync;
	logic [NFF-1:0][LGFIFO:0] wgray_sync;
	logic [LGFIFO:0]          wr_rgray;
	logic [LGFIFO:0]          rd_wgray;

	////////////////////////////////////////
	// Write side
	////////////////////////////////////////

	// Bytes offered while full are ignored
	assign wr_push = i_wr && !o_wr_full;
	assign wr_addr_nxt = wr_addr + 1'b1;

	always_ff @(posedge i_dstb_clk or negedge i_wr_reset_n)
	if (!i_wr_reset_n)
	begin
		wr_addr <= '0;
		wr_gray <= '0;
	end else if (wr_push)
	begin
		wr_addr <= wr_addr_nxt;
		wr_gray <= wr_addr_nxt ^ (wr_addr_nxt >> 1);
	end

	always_ff @(posedge i_dstb_clk)
	if (wr_push)
		mem[wr_addr[LGFIFO-1:0]] <= i_wr_data;

	// Read pointer into the strobe domain
	always_ff @(posedge i_dstb_clk or negedge i_wr_reset_n)
	if (!i_wr_reset_n)
		rgray_sync <= '0;
	else
		rgray_sync <= {rgray_sync[NFF-2:0], rd_gray};

	assign wr_rgray = rgray_sync[NFF-1];

	// Full when the read pointer sits one lap behind
	// Top two Gray bits differ, the rest match
	assign o_wr_full = (wr_rgray == {~wr_gray[LGFIFO:LGFIFO-1], wr_gray[LGFIFO-2:0]});

	////////////////////////////////////////
	// Read side
	////////////////////////////////////////

	// Write pointer into the system domain
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	if (!i_rd_reset_n)
		wgray_sync <= '0;
	else
		wgray_sync <= {wgray_sync[NFF-2:0], wr_gray};

	assign rd_wgray = wgray_sync[NFF-1];
	assign rd_empty = (rd_wgray == rd_gray);

	// Output register refills when empty or being taken
	assign rd_load = !o_rd_valid || i_rd_take;
	assign rd_pull = rd_load && !rd_empty;
	assign rd_addr_nxt = rd_addr + 1'b1;

	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	if (!i_rd_reset_n)
	begin
		rd_addr    <= '0;
		rd_gray    <= '0;
		o_rd_valid <= 1'b0;
	end else
	begin
		if (rd_load)
			o_rd_valid <= !rd_empty;
		if (rd_pull)
		begin
			rd_addr <= rd_addr_nxt;
			rd_gray <= rd_addr_nxt ^ (rd_addr_nxt >> 1);
		end
	end

	// Entry is stable in mem once its Gray pointer has crossed
	always_ff @(posedge gbl_clk)
	if (rd_pull)
		o_rd_data <= mem[rd_addr[LGFIFO-1:0]];

endmodule

// File: rtl/byte_pairer.sv
// Pairs FIFO bytes into words, high byte first
// A start-of-frame byte always opens a new word
module byte_pairer (
	input  logic                             gbl_clk,
	input  logic                             i_rd_reset_n,
	// FIFO read side
	input  logic                             i_fifo_valid,
	input  logic [strobe_rx_pkg::FIFO_W-1:0] i_fifo_data,
	output logic                             o_fifo_take,
	// Word output
	input  logic                             i_word_ready,
	output logic                             o_word_valid,
	output logic                             o_word_sof,
	output logic [strobe_rx_pkg::WORD_W-1:0] o_word_data
);
	import strobe_rx_pkg::*;

	// Fields of the FIFO entry
	logic [LINK_BYTE_W-1:0] in_byte;
	logic                   in_sof;

	// Pending high byte
	logic [LINK_BYTE_W-1:0] hi_byte;
	logic                   hi_sof;
	logic                   hi_valid;

	// Byte opens a new word
	logic                   start_word;

	assign in_byte = i_fifo_data[LINK_BYTE_W-1:0];
	assign in_sof  = i_fifo_data[FIFO_W-1];

	// Hold off the FIFO while a finished word waits
	assign o_fifo_take = i_fifo_valid && (!o_word_valid || i_word_ready);

	// Start of frame drops any unpaired byte
	assign start_word = in_sof || !hi_valid;

	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	if (!i_rd_reset_n)
	begin
		hi_valid     <= 1'b0;
		o_word_valid <= 1'b0;
	end else
	begin
		// Word consumed downstream
		if (i_word_ready)
			o_word_valid <= 1'b0;
		if (o_fifo_take)
		begin
			if (start_word)
				hi_valid <= 1'b1;
			else
			begin
				hi_valid     <= 1'b0;
				o_word_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge gbl_clk)
	if (o_fifo_take)
	begin
		if (start_word)
		begin
			hi_byte <= in_byte;
			hi_sof  <= in_sof;
		end else
		begin
			// Flag travels with the completed word
			o_word_data <= {hi_byte, in_byte};
			o_word_sof  <= hi_sof;
		end
	end

endmodule

// File: rtl/frame_decoder.sv
// Frame decoder, checks kind, length and the XOR check word
// Each payload word is held until the next word shows whether it is last
// A start of frame mid-frame flushes the held word with last and err set
module frame_decoder (
	input  logic                             gbl_clk,
	input  logic                             i_rd_reset_n,
	// Word input
	input  logic                             i_word_valid,
	input  logic                             i_word_sof,
	input  logic [strobe_rx_pkg::WORD_W-1:0] i_word_data,
	output logic                             o_word_ready,
	// Payload output
	input  logic                             i_pay_ready,
	output logic                             o_pay_valid,
	output logic [strobe_rx_pkg::WORD_W-1:0] o_pay_data,
	output logic [7:0]                       o_pay_tag,
	output logic                             o_pay_last,
	output logic                             o_pay_err
);
	import strobe_rx_pkg::*;

	// FSM states
	localparam logic [1:0] ST_IDLE    = 2'd0;
	localparam logic [1:0] ST_PAYLOAD = 2'd1;
	localparam logic [1:0] ST_CHECK   = 2'd2;
	localparam logic [1:0] ST_DISCARD = 2'd3;

	logic [1:0]        state;
	// Payload words still to come
	logic [3:0]        remain;
	logic [WORD_W-1:0] run_xor;
	logic [WORD_W-1:0] held;
	logic              held_valid;
	logic [7:0]        frame_tag;

	rx_word_u          in_w;
	logic              word_fire;
	logic              hdr_ok;

	// Release of the held word this cycle
	logic              emit;
	logic              emit_last;
	logic              emit_err;

	assign in_w = i_word_data;

	// Output register free, so any word may be taken
	assign o_word_ready = !o_pay_valid || i_pay_ready;
	assign word_fire    = i_word_valid && o_word_ready;

	// Only non-empty data frames are decoded
	assign hdr_ok = (in_w.hdr.kind == KIND_DATA) && (in_w.hdr.len != 4'd0);

	always_comb
	begin
		emit      = 1'b0;
		emit_last = 1'b0;
		emit_err  = 1'b0;
		if (word_fire)
		begin
			if (i_word_sof)
			begin
				// Truncated frame
				emit      = held_valid;
				emit_last = 1'b1;
				emit_err  = 1'b1;
			end else if (state == ST_PAYLOAD)
				emit = held_valid;
			else if (state == ST_CHECK)
			begin
				emit      = held_valid;
				emit_last = 1'b1;
				emit_err  = (run_xor != in_w.raw);
			end
		end
	end

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	if (!i_rd_reset_n)
	begin
		state       <= ST_IDLE;
		remain      <= 4'd0;
		held_valid  <= 1'b0;
		o_pay_valid <= 1'b0;
	end else
	begin
		if (i_pay_ready)
			o_pay_valid <= 1'b0;
		if (emit)
			o_pay_valid <= 1'b1;
		if (word_fire)
		begin
			if (i_word_sof)
			begin
				// Every start-of-frame word is a header
				held_valid <= 1'b0;
				remain     <= in_w.hdr.len;
				state      <= hdr_ok ? ST_PAYLOAD : ST_DISCARD;
			end else if (state == ST_PAYLOAD)
			begin
				held_valid <= 1'b1;
				remain     <= remain - 4'd1;
				if (remain == 4'd1)
					state <= ST_CHECK;
			end else if (state == ST_CHECK)
			begin
				held_valid <= 1'b0;
				state      <= ST_IDLE;
			end
			// Idle and discard drop words without a start of frame
		end
	end

	////////////////////////////////////////
	// Data path
	////////////////////////////////////////

	always_ff @(posedge gbl_clk)
	begin
		if (emit)
		begin
			o_pay_data <= held;
			o_pay_tag  <= frame_tag;
			o_pay_last <= emit_last;
			o_pay_err  <= emit_err;
		end
		if (word_fire)
		begin
			if (i_word_sof)
			begin
				// Check word covers the header too
				run_xor   <= in_w.raw;
				frame_tag <= in_w.hdr.tag;
			end else if (state == ST_PAYLOAD)
			begin
				held    <= in_w.raw;
				run_xor <= run_xor ^ in_w.raw;
			end
		end
	end

endmodule

// File: rtl/req_ack_sender.sv
// One-entry buffer driving a four-phase req/ack port
// i_ack is taken as synchronous to gbl_clk
// Output values change only while o_req and i_ack are both low
module req_ack_sender (
	input  logic                             gbl_clk,
	input  logic                             i_rd_reset_n,
	// Payload input
	input  logic                             i_pay_valid,
	input  logic [strobe_rx_pkg::WORD_W-1:0] i_pay_data,
	input  logic [7:0]                       i_pay_tag,
	input  logic                             i_pay_last,
	input  logic                             i_pay_err,
	output logic                             o_pay_ready,
	// Four-phase port
	input  logic                             i_ack,
	output logic                             o_req,
	output logic [strobe_rx_pkg::WORD_W-1:0] o_data,
	output logic [7:0]                       o_tag,
	output logic                             o_last,
	output logic                             o_err
);
	// Phase encoding keeps o_req on its own state bit
	localparam logic [1:0] ST_IDLE    = 2'b00;
	localparam logic [1:0] ST_REQUEST = 2'b01;
	localparam logic [1:0] ST_RELEASE = 2'b10;

	logic [1:0] state;

	// Buffer empty only in idle
	assign o_pay_ready = (state == ST_IDLE);
	assign o_req       = state[0];

	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	if (!i_rd_reset_n)
		state <= ST_IDLE;
	else
	begin
		case (state)
		ST_IDLE:
			if (i_pay_valid)
				state <= ST_REQUEST;
		ST_REQUEST:
			// Consumer has the word, drop req
			if (i_ack)
				state <= ST_RELEASE;
		ST_RELEASE:
			// Wait for the consumer to finish the exchange
			if (!i_ack)
				state <= ST_IDLE;
		default:
			state <= ST_IDLE;
		endcase
	end

	// Word loads only in idle
	always_ff @(posedge gbl_clk)
	if (i_pay_valid && o_pay_ready)
	begin
		o_data <= i_pay_data;
		o_tag  <= i_pay_tag;
		o_last <= i_pay_last;
		o_err  <= i_pay_err;
	end

endmodule

// File: rtl/strobe_rx_top.sv
// Strobe receive link top, FIFO then pairer, decoder and req/ack sender
// Transmitter holds a byte while o_dstb_full is high
// i_ack is taken as synchronous to gbl_clk
module strobe_rx_top #(
	parameter int LGFIFO = 3,
	parameter int NFF = 2
) (
	// Strobe domain
	input  logic                                  i_dstb_clk,
	input  logic                                  i_wr_reset_n,
	input  logic                                  i_dstb_valid,
	input  logic                                  i_dstb_sof,
	input  logic [strobe_rx_pkg::LINK_BYTE_W-1:0] i_dstb_data,
	output logic                                  o_dstb_full,
	// System domain
	input  logic                                  gbl_clk,
	input  logic                                  i_rd_reset_n,
	input  logic                                  i_ack,
	output logic                                  o_req,
	output logic [strobe_rx_pkg::WORD_W-1:0]      o_data,
	output logic [7:0]                            o_tag,
	output logic                                  o_last,
	output logic                                  o_err
);
	import strobe_rx_pkg::*;

	// FIFO entry, flag above the byte
	logic [FIFO_W-1:0] fifo_wr_data;

	// FIFO to pairer
	logic              fifo_rd_valid;
	logic [FIFO_W-1:0] fifo_rd_data;
	logic              fifo_rd_take;

	// Pairer to decoder
	logic              word_valid;
	logic              word_sof;
	logic [WORD_W-1:0] word_data;
	logic              word_ready;

	// Decoder to sender
	logic              pay_valid;
	logic [WORD_W-1:0] pay_data;
	logic [7:0]        pay_tag;
	logic              pay_last;
	logic              pay_err;
	logic              pay_ready;

	assign fifo_wr_data = {i_dstb_sof, i_dstb_data};

	////////////////////////////////////////
	// Clock crossing
	////////////////////////////////////////

	strobe_afifo #(
		.LGFIFO (LGFIFO),
		.NFF    (NFF)
	) afifo_i (
		.i_dstb_clk   (i_dstb_clk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr         (i_dstb_valid),
		.i_wr_data    (fifo_wr_data),
		.o_wr_full    (o_dstb_full),
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd_take    (fifo_rd_take),
		.o_rd_valid   (fifo_rd_valid),
		.o_rd_data    (fifo_rd_data)
	);

	////////////////////////////////////////
	// gbl_clk stages
	////////////////////////////////////////

	byte_pairer pairer_i (
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_fifo_valid (fifo_rd_valid),
		.i_fifo_data  (fifo_rd_data),
		.o_fifo_take  (fifo_rd_take),
		.i_word_ready (word_ready),
		.o_word_valid (word_valid),
		.o_word_sof   (word_sof),
		.o_word_data  (word_data)
	);

	frame_decoder decoder_i (
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_word_valid (word_valid),
		.i_word_sof   (word_sof),
		.i_word_data  (word_data),
		.o_word_ready (word_ready),
		.i_pay_ready  (pay_ready),
		.o_pay_valid  (pay_valid),
		.o_pay_data   (pay_data),
		.o_pay_tag    (pay_tag),
		.o_pay_last   (pay_last),
		.o_pay_err    (pay_err)
	);

	req_ack_sender sender_i (
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_pay_valid  (pay_valid),
		.i_pay_data   (pay_data),
		.i_pay_tag    (pay_tag),
		.i_pay_last   (pay_last),
		.i_pay_err    (pay_err),
		.o_pay_ready  (pay_ready),
		.i_ack        (i_ack),
		.o_req        (o_req),
		.o_data       (o_data),
		.o_tag        (o_tag),
		.o_last       (o_last),
		.o_err        (o_err)
	);

endmodule

// File: tests/tb_clkgen.sv
// Free-running testbench clock, starts low
// PERIOD should be even so both phases are equal
module tb_clkgen #(
	parameter int PERIOD = 8
) (
	output logic o_clk
);

	initial
	begin
		o_clk = 1'b0;
		// Half period per phase
		forever
			#(PERIOD / 2) o_clk = ~o_clk;
	end

endmodule

// File: tests/strobe_rx_tb.sv
// Directed tests for the strobe receive link on an 8 unit gbl_clk and a 14 unit strobe clock
// Inputs change and outputs are read 1 unit after their own clock edge
// Output words are checked in order against a queue built from the frame rules
// The first mismatch stops the run
module strobe_rx_tb;
	import strobe_rx_pkg::*;

	// Frames sent in the back-pressure test
	localparam int BP_FRAMES   = 12;
	// All frames over all tests for sizing the watchdog
	localparam int NUM_FRAMES  = 9 + BP_FRAMES;
	// Worst case time units for one frame under long ack delays
	localparam int FRAME_BOUND = 6000;
	// gbl_clk cycles allowed for a test's output to drain
	localparam int DRAIN_LIMIT = 10000;

	logic                   gbl_clk;
	logic                   dstb_clk;
	logic                   i_wr_reset_n;
	logic                   i_rd_reset_n;
	logic                   i_dstb_valid;
	logic                   i_dstb_sof;
	logic [LINK_BYTE_W-1:0] i_dstb_data;
	logic                   o_dstb_full;
	logic                   i_ack;
	logic                   o_req;
	logic [WORD_W-1:0]      o_data;
	logic [7:0]             o_tag;
	logic                   o_last;
	logic                   o_err;

	// Expected output words packed as {data, tag, last, err}
	logic [WORD_W+9:0]      exp_q[$];
	// Words of the frame about to be sent with the header first
	logic [WORD_W-1:0]      tx_words[$];
	string                  cur_test;
	logic [31:0]            lfsr_state;
	// Bits drawn per ack delay
	int                     ack_bits;
	logic                   saw_full;

	tb_clkgen #(.PERIOD(8)) gbl_clkgen_i (.o_clk(gbl_clk));
	tb_clkgen #(.PERIOD(14)) dstb_clkgen_i (.o_clk(dstb_clk));

	strobe_rx_top #(
		.LGFIFO (3),
		.NFF    (2)
	) dut_i (
		.i_dstb_clk   (dstb_clk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_dstb_valid (i_dstb_valid),
		.i_dstb_sof   (i_dstb_sof),
		.i_dstb_data  (i_dstb_data),
		.o_dstb_full  (o_dstb_full),
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_ack        (i_ack),
		.o_req        (o_req),
		.o_data       (o_data),
		.o_tag        (o_tag),
		.o_last       (o_last),
		.o_err        (o_err)
	);

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input logic [WORD_W+9:0] exp, input logic [WORD_W+9:0] act);
		if (exp !== act)
			abort_run($sformatf("Fail %s: expected %h, actual %h", cur_test, exp, act));
	endtask

	function automatic logic [WORD_W-1:0] make_header(input logic [3:0] kind,
		input logic [3:0] len, input logic [7:0] tag);
		rx_word_u h;
		h.hdr.kind = kind;
		h.hdr.len  = len;
		h.hdr.tag  = tag;
		return h.raw;
	endfunction

	// Header then len random payload words then the XOR check word
	task automatic build_frame(input logic [3:0] kind, input logic [3:0] len,
		input logic [7:0] tag, input logic corrupt);
		logic [31:0]       r;
		logic [WORD_W-1:0] chk;
		tx_words.delete();
		tx_words.push_back(make_header(kind, len, tag));
		chk = tx_words[0];
		for (int i = 0; i < int'(len); i++)
		begin
			draw_bits(WORD_W, r);
			tx_words.push_back(r[WORD_W-1:0]);
			chk = chk ^ r[WORD_W-1:0];
		end
		// One flipped bit breaks the check
		if (corrupt)
			chk = chk ^ 16'h0100;
		tx_words.push_back(chk);
	endtask

	task automatic expect_word(input logic [WORD_W-1:0] data, input logic [7:0] tag,
		input logic last, input logic err);
		exp_q.push_back({data, tag, last, err});
	endtask

	// Every payload word of the built frame with last and err only on the final one
	task automatic expect_frame(input logic [7:0] tag, input logic err);
		int n;
		n = tx_words.size();
		for (int i = 1; i < n - 1; i++)
			expect_word(tx_words[i], tag, i == n - 2, (i == n - 2) && err);
	endtask

	// Called 1 unit after a strobe edge where full stays stable until the next edge
	task automatic send_byte(input logic sof, input logic [LINK_BYTE_W-1:0] data);
		i_dstb_valid = 1'b1;
		i_dstb_sof   = sof;
		i_dstb_data  = data;
		// Hold the byte while the FIFO is full
		while (o_dstb_full)
		begin
			saw_full = 1'b1;
			@(posedge dstb_clk);
			#1;
		end
		@(posedge dstb_clk);
		#1;
		i_dstb_valid = 1'b0;
		i_dstb_sof   = 1'b0;
	endtask

	// First n words of the built frame sent high byte first with sof on the first byte
	task automatic send_words(input int n);
		for (int i = 0; i < n; i++)
		begin
			send_byte(i == 0, tx_words[i][WORD_W-1:LINK_BYTE_W]);
			send_byte(1'b0, tx_words[i][LINK_BYTE_W-1:0]);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		@(posedge dstb_clk);
		#1;
	endtask

	// Wait for every expected word and the end of the handshake
	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 || o_req)
		begin
			@(posedge gbl_clk);
			#1;
			cycles++;
			if (cycles > DRAIN_LIMIT)
				abort_run($sformatf("%s: expected output words never arrived", cur_test));
		end
		// Quiet period catches stray words
		repeat (40)
			@(posedge gbl_clk);
		#1;
	endtask

	////////////////////////////////////////
	// Consumer side of the req/ack port
	////////////////////////////////////////

	initial
	begin : ack_responder
		logic [31:0] delay;
		i_ack = 1'b0;
		forever
		begin
			@(posedge gbl_clk);
			#1;
			if (o_req && !i_ack)
			begin
				if (exp_q.size() == 0)
					abort_run($sformatf("%s: output word arrived when none was expected",
						cur_test));
				else
					check_value(exp_q.pop_front(), {o_data, o_tag, o_last, o_err});
				draw_bits(ack_bits, delay);
				repeat (delay)
				begin
					@(posedge gbl_clk);
					#1;
				end
				i_ack = 1'b1;
				// Drop ack once req has dropped
				while (o_req)
				begin
					@(posedge gbl_clk);
					#1;
				end
				i_ack = 1'b0;
			end
		end
	end

	initial
	begin : watchdog
		#(NUM_FRAMES * FRAME_BOUND + 200);
		abort_run($sformatf("Watchdog expired during %s, the run took too long", cur_test));
	end

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic test_good_frame();
		begin_test("good_frame");
		build_frame(KIND_DATA, 4'd3, 8'h3c, 1'b0);
		expect_frame(8'h3c, 1'b0);
		send_words(tx_words.size());
		// Longest frame straight after
		build_frame(KIND_DATA, 4'd15, 8'hc7, 1'b0);
		expect_frame(8'hc7, 1'b0);
		send_words(tx_words.size());
		wait_drain();
	endtask

	task automatic test_bad_check();
		begin_test("bad_check");
		build_frame(KIND_DATA, 4'd4, 8'h5a, 1'b1);
		expect_frame(8'h5a, 1'b1);
		send_words(tx_words.size());
		wait_drain();
	endtask

	task automatic test_dropped_frames();
		begin_test("dropped_frames");
		// Non-data kind
		build_frame(4'h6, 4'd3, 8'h11, 1'b0);
		send_words(tx_words.size());
		// Data kind with no payload
		build_frame(KIND_DATA, 4'd0, 8'h22, 1'b0);
		send_words(tx_words.size());
		build_frame(KIND_DATA, 4'd2, 8'h33, 1'b0);
		expect_frame(8'h33, 1'b0);
		send_words(tx_words.size());
		wait_drain();
	endtask

	task automatic test_truncation();
		begin_test("truncation");
		// Header and two of four payload words before a new frame
		build_frame(KIND_DATA, 4'd4, 8'h44, 1'b0);
		expect_word(tx_words[1], 8'h44, 1'b0, 1'b0);
		expect_word(tx_words[2], 8'h44, 1'b1, 1'b1);
		send_words(3);
		build_frame(KIND_DATA, 4'd2, 8'h55, 1'b0);
		expect_frame(8'h55, 1'b0);
		send_words(tx_words.size());
		wait_drain();
		begin_test("stray_byte");
		// Odd byte must not shift the next frame
		send_byte(1'b0, 8'ha5);
		build_frame(KIND_DATA, 4'd3, 8'h66, 1'b0);
		expect_frame(8'h66, 1'b0);
		send_words(tx_words.size());
		wait_drain();
	endtask

	task automatic test_back_pressure();
		logic [31:0] r;
		logic [3:0]  len;
		begin_test("back_pressure");
		ack_bits = 5;
		saw_full = 1'b0;
		for (int f = 0; f < BP_FRAMES; f++)
		begin
			draw_bits(4, r);
			len = (r[3:0] == 4'd0) ? 4'd1 : r[3:0];
			build_frame(KIND_DATA, len, 8'h80 | f[7:0], 1'b0);
			expect_frame(8'h80 | f[7:0], 1'b0);
			send_words(tx_words.size());
		end
		wait_drain();
		if (!saw_full)
			abort_run("back_pressure: o_dstb_full never went high");
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin : main_seq
		cur_test     = "reset";
		lfsr_state   = 32'he10cff4d;
		ack_bits     = 2;
		saw_full     = 1'b0;
		i_wr_reset_n = 1'b0;
		i_rd_reset_n = 1'b0;
		i_dstb_valid = 1'b0;
		i_dstb_sof   = 1'b0;
		i_dstb_data  = '0;
		repeat (10)
			@(posedge gbl_clk);
		#1;
		i_wr_reset_n = 1'b1;
		i_rd_reset_n = 1'b1;
		@(posedge gbl_clk);
		#1;
		if (o_req || o_dstb_full)
			abort_run("o_req or o_dstb_full is high after reset");
		test_good_frame();
		test_bad_check();
		test_dropped_frames();
		test_truncation();
		test_back_pressure();
		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: compile.f
rtl/strobe_rx_pkg.sv
rtl/strobe_afifo.sv
rtl/byte_pairer.sv
rtl/frame_decoder.sv
rtl/req_ack_sender.sv
rtl/strobe_rx_top.sv
tests/tb_clkgen.sv
tests/strobe_rx_tb.sv

// File: Makefile
# Verilator build and run for the strobe receive link testbench
# Override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= strobe_rx_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= TEST PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuild only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulation output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
